//--- common/fetch_pkg.sv
// Shared types for the instruction-fetch subsystem.
// Message structs for the memory, decode and control links, plus the tag
// layout helpers. Modules refer to these by scoped name.

`default_nettype none

package fetch_pkg;

  // ----------------------------------------------------------
  // basic words
  // ----------------------------------------------------------

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // tag carried on every memory request, echoed on the response
  localparam int unsigned tag_bits = 8;
  // epoch lives in the top tag bit
  localparam int unsigned tag_epoch_bit = tag_bits - 1;

  typedef logic [tag_bits-1:0] tag_t;

  // ----------------------------------------------------------
  // enums
  // ----------------------------------------------------------

  // reason for a squash, kept for decode bookkeeping
  typedef enum logic {
    squash_branch,
    squash_jump
  } squash_cause_e;

  // control register select
  typedef enum logic {
    reg_reset_vector,
    reg_run_enable
  } ctrl_reg_e;

  // ----------------------------------------------------------
  // messages
  // ----------------------------------------------------------

  typedef struct packed {
    addr_t addr;
    tag_t  tag;
  } mem_req_t;

  typedef struct packed {
    inst_t data;
    tag_t  tag;
  } mem_resp_t;

  // fetch to decode
  typedef struct packed {
    inst_t inst;
    addr_t pc;
  } fd_msg_t;

  // decode back to fetch
  typedef struct packed {
    logic          squash;
    squash_cause_e cause;
    addr_t         target;
  } redirect_t;

  typedef struct packed {
    logic        en;
    ctrl_reg_e   sel;
    logic [31:0] data;
  } ctrl_wr_t;

  // ----------------------------------------------------------
  // tag layout
  // ----------------------------------------------------------

  // epoch on top, wrapping sequence below (trace only)
  function automatic tag_t make_tag(input logic epoch, input logic [tag_bits-2:0] seq);
    return {epoch, seq};
  endfunction

  function automatic logic tag_epoch(input tag_t tag);
    return tag[tag_epoch_bit];
  endfunction

endpackage

`default_nettype wire

//--- fetch/fetch_ctrl_regs.sv
// Control registers for the fetch unit: reset vector and run enable.
// Written through a single strobe; also turns the rising edge of run
// into a one-cycle start pulse for the pc reload.

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  fetch_pkg::ctrl_wr_t  ctrl_wr,
  output fetch_pkg::addr_t     reset_vector,
  output logic                 run,
  output logic                 start
);

  // run delayed one cycle for edge detect
  logic run_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_vector <= '0;
      run          <= 1'b0;
      run_d        <= 1'b0;
    end else begin
      run_d <= run;
      if (ctrl_wr.en) begin
        case (ctrl_wr.sel)
          // low two bits dropped, fetch is word aligned
          fetch_pkg::reg_reset_vector: reset_vector <= {ctrl_wr.data[31:2], 2'b00};
          fetch_pkg::reg_run_enable:   run          <= ctrl_wr.data[0];
          default:                     run          <= run;
        endcase
      end
    end
  end

  // high in the first cycle run reads 1
  assign start = run & ~run_d;

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
// Fetch unit: pc sequencing, request issue to instruction memory, in-flight
// accounting, and epoch filtering of responses before they go to the buffer.
// Sits between fetch_ctrl_regs, inst_mem and fetch_resp_buf.

`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter int unsigned opaq_bits  = 8,
  parameter int unsigned resp_depth = 4
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  fetch_pkg::addr_t                 reset_vector,
  input  logic                             run,
  input  logic                             start,
  input  fetch_pkg::redirect_t             redirect,
  output fetch_pkg::mem_req_t              mem_req,
  output logic                             mem_req_val,
  input  logic                             mem_req_rdy,
  input  fetch_pkg::mem_resp_t             mem_resp,
  input  logic                             mem_resp_val,
  output logic                             mem_resp_rdy,
  output logic                             push,
  output fetch_pkg::fd_msg_t               push_msg,
  output logic                             flush,
  input  logic [$clog2(resp_depth+1)-1:0]  buf_free
);

  localparam int unsigned cnt_bits = $clog2(resp_depth + 1);
  // resp_depth is a power of two, so pointers wrap on their own
  localparam int unsigned ptr_bits = $clog2(resp_depth);
  // only opaq_bits-1 sequence bits are meaningful below the epoch
  localparam logic [fetch_pkg::tag_bits-2:0] seq_mask =
    (fetch_pkg::tag_bits-1)'((1 << (opaq_bits - 1)) - 1);

  fetch_pkg::addr_t                 pc;
  logic                             epoch;
  logic [fetch_pkg::tag_bits-2:0]   seq;
  logic [cnt_bits-1:0]              inflight;

  // pcs of outstanding requests, oldest at rd_ptr
  fetch_pkg::addr_t                 pc_q [resp_depth];
  logic [ptr_bits-1:0]              wr_ptr;
  logic [ptr_bits-1:0]              rd_ptr;

  logic squash;
  logic req_fire;
  logic resp_fire;
  logic epoch_ok;

  // ----------------------------------------------------------
  // request side
  // ----------------------------------------------------------

  assign squash = redirect.squash;

  // start cycle only reloads the pc, first request goes out next cycle
  // inflight + occupancy < depth, written as inflight < free
  assign mem_req_val  = run & ~start & ~squash & (inflight < buf_free);
  assign mem_req.addr = pc;
  assign mem_req.tag  = fetch_pkg::make_tag(epoch, seq);

  assign req_fire  = mem_req_val & mem_req_rdy;

  // ----------------------------------------------------------
  // response side
  // ----------------------------------------------------------

  // space is reserved at issue time, never back-pressure memory
  assign mem_resp_rdy = 1'b1;
  assign resp_fire    = mem_resp_val & mem_resp_rdy;

  // stale epoch or a squash this cycle means drop
  assign epoch_ok      = fetch_pkg::tag_epoch(mem_resp.tag) == epoch;
  assign push          = resp_fire & epoch_ok & ~squash;
  assign push_msg.inst = mem_resp.data;
  assign push_msg.pc   = pc_q[rd_ptr];

  assign flush = squash;

  always_ff @(posedge clk) begin
    if (req_fire) begin
      pc_q[wr_ptr] <= pc;
    end
  end

  // ----------------------------------------------------------
  // state
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // matches the reset value of the reset vector register
      pc       <= '0;
      epoch    <= 1'b0;
      seq      <= '0;
      inflight <= '0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
    end else begin
      // restart takes priority over a redirect
      if (start) begin
        pc <= reset_vector;
      end else if (squash) begin
        pc <= {redirect.target[31:2], 2'b00};
      end else if (req_fire) begin
        pc <= pc + 32'd4;
      end

      // both squash causes handled the same here
      if (squash) begin
        epoch <= ~epoch;
      end

      if (req_fire) begin
        seq    <= (seq + 1'b1) & seq_mask;
        wr_ptr <= wr_ptr + 1'b1;
      end

      // dropped responses still retire their queue slot
      if (resp_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({req_fire, resp_fire})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // issue limit together with buffer free count bounds the outstanding set
  a_inflight_bound: assert property (@(posedge clk) disable iff (!arst_n)
    inflight <= cnt_bits'(resp_depth));

  // a squash points the next request at the word-aligned target
  a_squash_target: assert property (@(posedge clk) disable iff (!arst_n)
    redirect.squash && !start |=> mem_req.addr == {$past(redirect.target[31:2]), 2'b00});

endmodule

`default_nettype wire

//--- fetch/fetch_resp_buf.sv
// Response buffer between fetch and decode.
// Circular FIFO of instruction/pc pairs; pops on an fd transfer and is
// emptied in one cycle by flush. Reports its free count back to fetch.

`timescale 1ns/1ps
`default_nettype none

module fetch_resp_buf #(
  parameter int unsigned resp_depth = 4
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             push,
  input  fetch_pkg::fd_msg_t               push_msg,
  input  logic                             flush,
  output fetch_pkg::fd_msg_t               fd,
  output logic                             fd_val,
  input  logic                             fd_rdy,
  output logic [$clog2(resp_depth+1)-1:0]  free
);

  localparam int unsigned cnt_bits = $clog2(resp_depth + 1);
  localparam int unsigned ptr_bits = $clog2(resp_depth);

  fetch_pkg::fd_msg_t   entries [resp_depth];
  logic [ptr_bits-1:0]  wr_ptr;
  logic [ptr_bits-1:0]  rd_ptr;
  logic [cnt_bits-1:0]  count;
  logic                 pop;

  // head straight from the array, no bypass of a fresh push
  assign fd     = entries[rd_ptr];
  assign fd_val = count != '0;
  assign pop    = fd_val & fd_rdy;
  assign free   = cnt_bits'(resp_depth) - count;

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= push_msg;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // a pop in the flush cycle has already been taken by decode
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // fetch reserves space per request, so a push never meets a full buffer
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> count < cnt_bits'(resp_depth));

  // decode side handshake: held head stays put unless flushed
  a_fd_stable: assert property (@(posedge clk) disable iff (!arst_n)
    fd_val && !fd_rdy && !flush |=> fd_val && $stable(fd));

endmodule

`default_nettype wire

//--- rtl/inst_mem.sv
// Instruction memory with valid/ready request and response ports.
// Response is valid one cycle after a request is accepted and echoes the
// request tag. A separate load port fills the array before fetch starts.

`timescale 1ns/1ps
`default_nettype none

module inst_mem #(
  parameter int unsigned mem_words = 256
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  load_en,
  input  fetch_pkg::addr_t      load_addr,
  input  fetch_pkg::inst_t      load_data,
  input  fetch_pkg::mem_req_t   req,
  input  logic                  req_val,
  output logic                  req_rdy,
  output fetch_pkg::mem_resp_t  resp,
  output logic                  resp_val,
  input  logic                  resp_rdy
);

  // word index from the bits above the byte offset
  localparam int unsigned idx_bits = $clog2(mem_words);

  fetch_pkg::inst_t     words [mem_words];
  logic [idx_bits-1:0]  load_idx;
  logic [idx_bits-1:0]  req_idx;
  logic                 req_fire;

  assign load_idx = load_addr[idx_bits+1:2];
  assign req_idx  = req.addr[idx_bits+1:2];

  // ----------------------------------------------------------
  // request acceptance
  // ----------------------------------------------------------

  // one response slot: free now, or being drained this cycle
  assign req_rdy  = ~resp_val | resp_rdy;
  assign req_fire = req_val & req_rdy;

  // ----------------------------------------------------------
  // array and response register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load_en) begin
      words[load_idx] <= load_data;
    end
    // a read racing a load of the same word sees the old word
    if (req_fire) begin
      resp.data <= words[req_idx];
      resp.tag  <= req.tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_val <= 1'b0;
    end else if (req_fire) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // requester keeps its pc word aligned
  a_req_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    req_val |-> req.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- rtl/fetch_subsys.sv
// Top level of the fetch subsystem.
// Wires the control registers, fetch unit, response buffer and instruction
// memory together; parameters are set here and passed down.

`timescale 1ns/1ps
`default_nettype none

module fetch_subsys #(
  parameter int unsigned opaq_bits  = 8,
  parameter int unsigned resp_depth = 4,
  parameter int unsigned mem_words  = 256
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  fetch_pkg::ctrl_wr_t   ctrl_wr,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  mem_load_en,
  input  fetch_pkg::addr_t      mem_load_addr,
  input  fetch_pkg::inst_t      mem_load_data,
  output fetch_pkg::fd_msg_t    fd,
  output logic                  fd_val,
  input  logic                  fd_rdy
);

  localparam int unsigned cnt_bits = $clog2(resp_depth + 1);

  // ----------------------------------------------------------
  // internal links
  // ----------------------------------------------------------

  // control to fetch
  fetch_pkg::addr_t      reset_vector;
  logic                  run;
  logic                  start;

  // fetch to memory and back
  fetch_pkg::mem_req_t   mem_req;
  logic                  mem_req_val;
  logic                  mem_req_rdy;
  fetch_pkg::mem_resp_t  mem_resp;
  logic                  mem_resp_val;
  logic                  mem_resp_rdy;

  // fetch to buffer
  logic                  push;
  fetch_pkg::fd_msg_t    push_msg;
  logic                  flush;
  logic [cnt_bits-1:0]   buf_free;

  // ----------------------------------------------------------
  // instances
  // ----------------------------------------------------------

  fetch_ctrl_regs i_fetch_ctrl_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .ctrl_wr      (ctrl_wr),
    .reset_vector (reset_vector),
    .run          (run),
    .start        (start)
  );

  fetch_unit #(
    .opaq_bits  (opaq_bits),
    .resp_depth (resp_depth)
  ) i_fetch_unit (
    .clk          (clk),
    .arst_n       (arst_n),
    .reset_vector (reset_vector),
    .run          (run),
    .start        (start),
    .redirect     (redirect),
    .mem_req      (mem_req),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp     (mem_resp),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .push         (push),
    .push_msg     (push_msg),
    .flush        (flush),
    .buf_free     (buf_free)
  );

  fetch_resp_buf #(
    .resp_depth (resp_depth)
  ) i_fetch_resp_buf (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (push),
    .push_msg (push_msg),
    .flush    (flush),
    .fd       (fd),
    .fd_val   (fd_val),
    .fd_rdy   (fd_rdy),
    .free     (buf_free)
  );

  inst_mem #(
    .mem_words (mem_words)
  ) i_inst_mem (
    .clk       (clk),
    .arst_n    (arst_n),
    .load_en   (mem_load_en),
    .load_addr (mem_load_addr),
    .load_data (mem_load_data),
    .req       (mem_req),
    .req_val   (mem_req_val),
    .req_rdy   (mem_req_rdy),
    .resp      (mem_resp),
    .resp_val  (mem_resp_val),
    .resp_rdy  (mem_resp_rdy)
  );

endmodule

`default_nettype wire

//--- dv/fetch_subsys_tb.sv
// Testbench for the fetch subsystem.
// Preloads instruction memory, then runs a table of control writes, stall
// modes, squashes and delivery checks against a small pc model.

`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_tb;

  localparam int unsigned resp_depth = 4;
  localparam int unsigned mem_words  = 256;
  localparam int unsigned clk_half   = 20;

  // table operations
  typedef enum logic [2:0] {
    op_idle,
    op_write_rv,
    op_stall,
    op_start,
    op_expect,
    op_squash,
    op_stop
  } op_e;

  typedef struct packed {
    op_e              op;
    logic [31:0]      arg;
    fetch_pkg::addr_t target;
  } row_t;

  logic                  clk;
  logic                  arst_n;
  fetch_pkg::ctrl_wr_t   ctrl_wr;
  fetch_pkg::redirect_t  redirect;
  logic                  mem_load_en;
  fetch_pkg::addr_t      mem_load_addr;
  fetch_pkg::inst_t      mem_load_data;
  fetch_pkg::fd_msg_t    fd;
  logic                  fd_val;
  logic                  fd_rdy;

  row_t              rows [$];
  // reference model state
  fetch_pkg::addr_t  model_pc;
  fetch_pkg::addr_t  model_rv;
  logic [31:0]       rng;
  logic              stall_on;
  int                err_cnt;
  int                check_cnt;
  int                deliv_cnt;

  fetch_subsys #(
    .opaq_bits  (8),
    .resp_depth (resp_depth),
    .mem_words  (mem_words)
  ) i_fetch_subsys (
    .clk           (clk),
    .arst_n        (arst_n),
    .ctrl_wr       (ctrl_wr),
    .redirect      (redirect),
    .mem_load_en   (mem_load_en),
    .mem_load_addr (mem_load_addr),
    .mem_load_data (mem_load_data),
    .fd            (fd),
    .fd_val        (fd_val),
    .fd_rdy        (fd_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  // memory image: each word is its byte address xor a fixed pattern
  function automatic fetch_pkg::inst_t image_word(input fetch_pkg::addr_t addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  function automatic fetch_pkg::fd_msg_t expected_msg(input fetch_pkg::addr_t pc);
    fetch_pkg::fd_msg_t m;
    m.inst = image_word(pc);
    m.pc   = pc;
    return m;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string op_label(input op_e op);
    case (op)
      op_idle:     return "idle";
      op_write_rv: return "write_rv";
      op_stall:    return "stall";
      op_start:    return "start";
      op_expect:   return "expect";
      op_squash:   return "squash";
      default:     return "stop";
    endcase
  endfunction

  task automatic add_row(input op_e op, input logic [31:0] arg, input fetch_pkg::addr_t target);
    row_t r;
    r.op     = op;
    r.arg    = arg;
    r.target = target;
    rows.push_back(r);
  endtask

  // deliveries the table asks for, sizes the watchdog
  function automatic int expected_deliveries();
    int sum;
    sum = 0;
    foreach (rows[i]) begin
      if (rows[i].op == op_expect || rows[i].op == op_squash) begin
        sum = sum + int'(rows[i].arg);
      end
    end
    return sum;
  endfunction

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  task automatic check_fd(input fetch_pkg::fd_msg_t act, input fetch_pkg::fd_msg_t exp);
    check_cnt = check_cnt + 1;
    if (act !== exp) begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t fd exp pc=%h inst=%h got pc=%h inst=%h",
               $time, exp.pc, exp.inst, act.pc, act.inst);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    check_cnt = check_cnt + 1;
    if (act !== exp) begin
      err_cnt = err_cnt + 1;
      $display("ERR %0t %s exp %b got %b", $time, name, exp, act);
    end
  endtask

  // ------------------------------------------------------------
  // cycle tasks
  // ------------------------------------------------------------

  // to the drive point, strobes are one cycle wide
  task automatic next_edge();
    @(posedge clk);
    #2;
    ctrl_wr  = '0;
    redirect = '0;
  endtask

  // one decode cycle, fd and fd_val are registered so stable here
  task automatic watch_cycle(output logic took);
    if (stall_on) begin
      rng    = xorshift32(rng);
      fd_rdy = rng[7];
    end else begin
      fd_rdy = 1'b1;
    end
    #1;
    took = fd_val & fd_rdy;
    if (took) begin
      check_fd(fd, expected_msg(model_pc));
      model_pc  = model_pc + 32'd4;
      deliv_cnt = deliv_cnt + 1;
    end
    next_edge();
  endtask

  task automatic deliver_n(input int n);
    int   got;
    logic took;
    got = 0;
    while (got < n) begin
      watch_cycle(took);
      if (took) begin
        got = got + 1;
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    int   c;
    int   drained;
    logic took;
    case (r.op)
      op_idle: begin
        for (c = 0; c < int'(r.arg); c++) begin
          fd_rdy = 1'b1;
          #1;
          check_bit("fd_val", fd_val, 1'b0);
          next_edge();
        end
      end
      op_write_rv: begin
        ctrl_wr.en   = 1'b1;
        ctrl_wr.sel  = fetch_pkg::reg_reset_vector;
        ctrl_wr.data = r.target;
        model_rv     = {r.target[31:2], 2'b00};
        next_edge();
      end
      op_stall: begin
        // zero turns stalls off, else it seeds the generator
        stall_on = r.arg != 32'd0;
        rng      = r.arg;
      end
      op_start: begin
        ctrl_wr.en   = 1'b1;
        ctrl_wr.sel  = fetch_pkg::reg_run_enable;
        ctrl_wr.data = 32'd1;
        fd_rdy       = 1'b1;
        model_pc     = model_rv;
        next_edge();
        // run captured, first word due on the third edge after
        for (c = 1; c <= 3; c++) begin
          next_edge();
          #1;
          check_bit("fd_val", fd_val, c == 3);
        end
      end
      op_expect: begin
        deliver_n(int'(r.arg));
      end
      op_squash: begin
        deliver_n(int'(r.arg));
        redirect.squash = 1'b1;
        redirect.target = r.target;
        if (r.arg == 32'd0) begin
          redirect.cause = fetch_pkg::squash_jump;
        end else begin
          redirect.cause = fetch_pkg::squash_branch;
        end
        // an item taken in the squash cycle still counts
        watch_cycle(took);
        model_pc = {r.target[31:2], 2'b00};
      end
      default: begin
        ctrl_wr.en   = 1'b1;
        ctrl_wr.sel  = fetch_pkg::reg_run_enable;
        ctrl_wr.data = 32'd0;
        drained      = 0;
        for (c = 0; c < int'(r.arg); c++) begin
          watch_cycle(took);
          if (took) begin
            drained = drained + 1;
          end
        end
        if (drained > int'(resp_depth)) begin
          err_cnt = err_cnt + 1;
          $display("run cleared but %0d more words were delivered, limit is %0d",
                   drained, resp_depth);
        end
        check_bit("fd_val", fd_val, 1'b0);
      end
    endcase
  endtask

  // ------------------------------------------------------------
  // table and main sequence
  // ------------------------------------------------------------

  task automatic build_table();
    add_row(op_idle,     32'd20,   32'h0);
    add_row(op_write_rv, 32'd0,    32'h40);
    add_row(op_stall,    32'd0,    32'h0);
    add_row(op_start,    32'd0,    32'h0);
    add_row(op_expect,   32'd16,   32'h0);
    add_row(op_stall,    32'h1325, 32'h0);
    add_row(op_expect,   32'd40,   32'h0);
    add_row(op_squash,   32'd5,    32'h80);
    add_row(op_expect,   32'd8,    32'h0);
    // back to back redirects, second target wins
    add_row(op_squash,   32'd3,    32'h100);
    add_row(op_squash,   32'd0,    32'h180);
    add_row(op_expect,   32'd10,   32'h0);
    add_row(op_stall,    32'd0,    32'h0);
    add_row(op_stop,     32'd20,   32'h0);
    add_row(op_idle,     32'd10,   32'h0);
    add_row(op_start,    32'd0,    32'h0);
    add_row(op_expect,   32'd6,    32'h0);
  endtask

  initial begin
    int i;
    int errs_before;
    build_table();
    arst_n        = 1'b0;
    ctrl_wr       = '0;
    redirect      = '0;
    mem_load_en   = 1'b0;
    mem_load_addr = '0;
    mem_load_data = '0;
    fd_rdy        = 1'b0;
    model_pc      = '0;
    model_rv      = '0;
    rng           = 32'h1325;
    stall_on      = 1'b0;
    err_cnt       = 0;
    check_cnt     = 0;
    deliv_cnt     = 0;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // fill every word through the load port
    for (i = 0; i < int'(mem_words); i++) begin
      mem_load_en   = 1'b1;
      mem_load_addr = i * 4;
      mem_load_data = image_word(mem_load_addr);
      next_edge();
    end
    mem_load_en = 1'b0;

    for (i = 0; i < rows.size(); i++) begin
      errs_before = err_cnt;
      apply_row(rows[i]);
      $display("row %0d %s arg %0h: %s", i, op_label(rows[i].op), rows[i].arg,
               (err_cnt == errs_before) ? "ok" : "mismatch");
    end

    $display("checks %0d, deliveries %0d, errors %0d", check_cnt, deliv_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog, 20 cycles per expected word plus preload and slack
  initial begin
    int limit;
    #1;
    limit = expected_deliveries() * 20 + 200 + int'(mem_words);
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles before the table completed", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
common/fetch_pkg.sv
fetch/fetch_ctrl_regs.sv
fetch/fetch_unit.sv
fetch/fetch_resp_buf.sv
rtl/inst_mem.sv
rtl/fetch_subsys.sv
dv/fetch_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fetch subsystem testbench with Verilator, runs it, and
# decides pass or fail by searching the simulation log.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log
sim_bin=sim_fetch_subsys

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module fetch_subsys_tb \
  --Mdir "$build_dir" -o "$sim_bin" > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status, see $build_log"
  exit 1
fi

"./$build_dir/$sim_bin" > "$sim_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see $sim_log"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" "$sim_log"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail, see $sim_log"
exit 1
